// File: hw/uartRxPkg.sv
//////////////////////////////////////////////////////////////////////
// Shared constants of the UART receive subsystem
// Frame format is fixed at 8 data bits and 1 stop bit, no parity
// Register map assumes a 4-bit AXI4-Lite address and 32-bit data
//////////////////////////////////////////////////////////////////////
`default_nettype none

package uartRxPkg;
	localparam int dataBits = 8;
	localparam int fifoAddrBits = 4;
	localparam int fifoEntries = 16;
	localparam int fifoHalf = 8;                 // Half-full threshold
	localparam int divBits = 16;
	localparam logic [divBits-1:0] defaultBaudDiv = 16'd16;   // Clocks per bit
	localparam logic [divBits-1:0] minBaudDiv = 16'd4;

	////////////////////////////////////////////////////////////////////
	// Register map
	localparam int addrBits = 4;
	localparam int regBits = 32;
	localparam logic [addrBits-1:0] addrData = 4'h0;
	localparam logic [addrBits-1:0] addrStatus = 4'h4;
	localparam logic [addrBits-1:0] addrCtrl = 4'h8;
	localparam int stEmpty = 0;
	localparam int stHalf = 1;
	localparam int stOverflow = 2;
	localparam int stFrameErr = 3;
	localparam int stBistDone = 4;
	localparam int stBistPass = 5;
	localparam int ctrlBistBit = 16;

	////////////////////////////////////////////////////////////////////
	// Self-test
	localparam int bistLen = 4;
	localparam int bistCntBits = 3;              // Counts 0 to bistLen
	localparam int frameBits = 11;               // Start, 8 data, stop, idle
	localparam logic [bistLen-1:0][dataBits-1:0] bistPattern =
		{8'hF0, 8'h0F, 8'hAA, 8'h55};            // Sent from index 0 up
endpackage

`default_nettype wire

// File: hw/fifoIf.sv
//////////////////////////////////////////////////////////////////////
// FIFO status, pop request and head data between FIFO and registers
// pop is a single-cycle request, head is valid only while not empty
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface fifoIf;
	logic empty;
	logic halfFull;
	logic overflow;
	logic pop;
	logic [uartRxPkg::dataBits-1:0] head;   // Oldest entry

	modport fifo (output empty, halfFull, overflow, head, input pop);
	modport host (input empty, halfFull, overflow, head, output pop);
endinterface

`default_nettype wire

// File: hw/uartRxSampler.sv
//////////////////////////////////////////////////////////////////////
// Serial receiver, 8N1, LSB first
// baudDiv is in clocks per bit and must not change during a frame
// Byte is strobed near the middle of the stop bit, a low stop bit
// gives a frameErr pulse and no byte
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uartRxSampler (
	input logic Clk,
	input logic rst,
	input logic rxLine,
	input logic [uartRxPkg::divBits-1:0] baudDiv,
	output logic [uartRxPkg::dataBits-1:0] rxByte,
	output logic byteValid,
	output logic frameErr
);
	logic rxMeta, rxSync, rxPrev;            // Synchronizer and edge detect
	logic [uartRxPkg::divBits-1:0] cnt;
	logic [uartRxPkg::divBits-1:0] halfDiv;
	logic [2:0] bitIdx;
	enum logic [1:0] {sIdle, sStart, sData, sStop} state;

	assign halfDiv = baudDiv >> 1;

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
			state <= sIdle;
			cnt <= '0;
			bitIdx <= '0;
			byteValid <= 1'b0;
			frameErr <= 1'b0;
		end
		else
		begin
			rxMeta <= rxLine;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
			byteValid <= 1'b0;
			frameErr <= 1'b0;
			case (state)
				sIdle:
				begin
					cnt <= '0;
					if (rxPrev && !rxSync)
						state <= sStart;                 // Falling start edge
				end
				sStart:
				begin
					if (cnt == halfDiv - 1'b1)
					begin
						cnt <= '0;
						bitIdx <= '0;
						state <= rxSync ? sIdle : sData; // Glitch goes back to idle
					end
					else
						cnt <= cnt + 1'b1;
				end
				sData:
				begin
					if (cnt == baudDiv - 1'b1)
					begin
						cnt <= '0;
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7)
							state <= sStop;
					end
					else
						cnt <= cnt + 1'b1;
				end
				default:
				begin
					// Stop bit sampled one divisor after the last data bit
					if (cnt == baudDiv - 1'b1)
					begin
						cnt <= '0;
						state <= sIdle;
						byteValid <= rxSync;
						frameErr <= !rxSync;
					end
					else
						cnt <= cnt + 1'b1;
				end
			endcase
		end
	end

	// Data shifts in from the top, so bit 0 lands in rxByte[0]
	always_ff @(posedge Clk)
	begin
		if (state == sData && cnt == baudDiv - 1'b1)
			rxByte <= {rxSync, rxByte[uartRxPkg::dataBits-1:1]};
	end
endmodule

`default_nettype wire

// File: hw/rxFifo.sv
//////////////////////////////////////////////////////////////////////
// Circular receive FIFO, 16 entries
// A push into a full FIFO is dropped, a pop on empty is ignored
// Flags are registered, overflow holds until the next pop
// All state is frozen while bistMode is high
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rxFifo (
	input logic Clk,
	input logic rst,
	input logic [uartRxPkg::dataBits-1:0] wrData,
	input logic wrEn,
	input logic bistMode,
	fifoIf.fifo f
);
	logic [uartRxPkg::dataBits-1:0] mem [uartRxPkg::fifoEntries];
	logic [uartRxPkg::fifoAddrBits-1:0] rdPtr, wrPtr;
	logic [uartRxPkg::fifoAddrBits:0] count, nextCount;
	logic doPush, doPop;

	assign doPush = wrEn && !bistMode && (count != uartRxPkg::fifoEntries);
	assign doPop = f.pop && !bistMode && (count != 0);
	assign nextCount = count + doPush - doPop;
	assign f.head = mem[rdPtr];         // Shown ahead of the pop

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
			f.empty <= 1'b1;
			f.halfFull <= 1'b0;
			f.overflow <= 1'b0;
		end
		else if (!bistMode)
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			count <= nextCount;
			f.empty <= (nextCount == 0);
			f.halfFull <= (nextCount >= uartRxPkg::fifoHalf);
			// Any pop clears overflow, reaching full sets it
			if (doPop)
				f.overflow <= 1'b0;
			else if (nextCount == uartRxPkg::fifoEntries)
				f.overflow <= 1'b1;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (doPush)
			mem[wrPtr] <= wrData;
	end
endmodule

`default_nettype wire

// File: hw/uartBist.sv
//////////////////////////////////////////////////////////////////////
// Receiver self-test
// Sends the fixed pattern through the sampler at the current divisor,
// one idle bit after each frame, and compares what comes back
// A start request while a test runs is ignored
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uartBist (
	input logic Clk,
	input logic rst,
	input logic bistStart,
	input logic [uartRxPkg::divBits-1:0] baudDiv,
	input logic rxPin,
	input logic [uartRxPkg::dataBits-1:0] rxByte,
	input logic byteValid,
	input logic frameErr,
	output logic lineOut,
	output logic bistMode,
	output logic bistDone,
	output logic bistPass
);
	logic [uartRxPkg::frameBits-1:0] shiftReg;   // Bit 0 is on the line
	logic [uartRxPkg::divBits-1:0] cnt;
	logic [3:0] bitCnt;
	logic [uartRxPkg::bistCntBits-1:0] txIdx, rxIdx;
	logic passOk;

	assign lineOut = bistMode ? shiftReg[0] : rxPin;

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			bistMode <= 1'b0;
			bistDone <= 1'b0;
			bistPass <= 1'b0;
			passOk <= 1'b0;
			shiftReg <= '1;
			cnt <= '0;
			bitCnt <= '0;
			txIdx <= '0;
			rxIdx <= '0;
		end
		else if (!bistMode)
		begin
			if (bistStart)
			begin
				bistMode <= 1'b1;
				bistDone <= 1'b0;
				bistPass <= 1'b0;
				passOk <= 1'b1;
				shiftReg <= {2'b11, uartRxPkg::bistPattern[0], 1'b0};
				cnt <= '0;
				bitCnt <= '0;
				txIdx <= '0;
				rxIdx <= '0;
			end
		end
		else
		begin
			////////////////////////////////////////////////////////////
			// Checker
			if (byteValid)
			begin
				rxIdx <= rxIdx + 1'b1;
				if (rxIdx >= uartRxPkg::bistLen)
					passOk <= 1'b0;                 // Extra byte
				else if (rxByte != uartRxPkg::bistPattern[rxIdx])
					passOk <= 1'b0;
			end
			if (frameErr)
				passOk <= 1'b0;

			////////////////////////////////////////////////////////////
			// Serializer
			if (cnt == baudDiv - 1'b1)
			begin
				cnt <= '0;
				if (bitCnt == uartRxPkg::frameBits - 1)
				begin
					bitCnt <= '0;
					if (txIdx == uartRxPkg::bistLen - 1)
					begin
						bistMode <= 1'b0;
						bistDone <= 1'b1;
						bistPass <= passOk && (rxIdx == uartRxPkg::bistLen);
					end
					else
					begin
						txIdx <= txIdx + 1'b1;
						shiftReg <= {2'b11, uartRxPkg::bistPattern[txIdx + 1'b1], 1'b0};
					end
				end
				else
				begin
					bitCnt <= bitCnt + 1'b1;
					shiftReg <= {1'b1, shiftReg[uartRxPkg::frameBits-1:1]};
				end
			end
			else
				cnt <= cnt + 1'b1;
		end
	end
endmodule

`default_nettype wire

// File: hw/axiLiteRegs.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite register slave, one outstanding read and one write
// Responses are always OKAY, unmapped reads return 0
// Data read pops the FIFO, status read clears the frame-error bit
// Divisor writes honor wstrb and are clamped to minBaudDiv
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axiLiteRegs (
	input logic Clk,
	input logic rst,
	input logic [uartRxPkg::addrBits-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [uartRxPkg::regBits-1:0] wdata,
	input logic [uartRxPkg::regBits/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [uartRxPkg::addrBits-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [uartRxPkg::regBits-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic frameErr,
	input logic bistDone,
	input logic bistPass,
	output logic [uartRxPkg::divBits-1:0] baudDiv,
	output logic bistStart,
	fifoIf.host f
);
	logic wrAccept, rdAccept;
	logic ctrlWrite;
	logic frameErrSticky;
	logic [uartRxPkg::divBits-1:0] newDiv;
	logic [uartRxPkg::regBits-1:0] statusWord;

	assign wrAccept = awvalid && wvalid && !bvalid;
	assign rdAccept = arvalid && !rvalid;
	assign awready = wrAccept;
	assign wready = wrAccept;
	assign arready = rdAccept;
	assign bresp = 2'b00;
	assign rresp = 2'b00;
	assign ctrlWrite = wrAccept && (awaddr == uartRxPkg::addrCtrl);
	assign f.pop = rdAccept && (araddr == uartRxPkg::addrData);   // FIFO ignores it when empty

	// Byte lanes 0 and 1 carry the divisor
	assign newDiv = {wstrb[1] ? wdata[15:8] : baudDiv[15:8],
		wstrb[0] ? wdata[7:0] : baudDiv[7:0]};

	always_comb
	begin
		statusWord = '0;
		statusWord[uartRxPkg::stEmpty] = f.empty;
		statusWord[uartRxPkg::stHalf] = f.halfFull;
		statusWord[uartRxPkg::stOverflow] = f.overflow;
		statusWord[uartRxPkg::stFrameErr] = frameErrSticky;
		statusWord[uartRxPkg::stBistDone] = bistDone;
		statusWord[uartRxPkg::stBistPass] = bistPass;
	end

	//////////////////////////////////////////////////////////////////////
	// Write channel and control register
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			bvalid <= 1'b0;
			baudDiv <= uartRxPkg::defaultBaudDiv;
			bistStart <= 1'b0;
		end
		else
		begin
			if (wrAccept)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (ctrlWrite)
				baudDiv <= (newDiv < uartRxPkg::minBaudDiv) ? uartRxPkg::minBaudDiv : newDiv;
			bistStart <= ctrlWrite && wstrb[2] && wdata[uartRxPkg::ctrlBistBit]; // One pulse
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read channel
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			rvalid <= 1'b0;
			frameErrSticky <= 1'b0;
		end
		else
		begin
			if (rdAccept)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			// A new error wins over the clear of a status read
			if (frameErr)
				frameErrSticky <= 1'b1;
			else if (rdAccept && araddr == uartRxPkg::addrStatus)
				frameErrSticky <= 1'b0;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (rdAccept)
		begin
			case (araddr)
				uartRxPkg::addrData: rdata <= f.empty ? '0 : {24'b0, f.head};
				uartRxPkg::addrStatus: rdata <= statusWord;
				uartRxPkg::addrCtrl: rdata <= {16'b0, baudDiv};  // Start bit reads 0
				default: rdata <= '0;
			endcase
		end
	end
endmodule

`default_nettype wire

// File: hw/uartRxTop.sv
//////////////////////////////////////////////////////////////////////
// UART receive subsystem top level
// rxPin is asynchronous and idles high
// A byte is readable two cycles after its stop bit is sampled
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uartRxTop (
	input logic Clk,
	input logic rst,
	input logic rxPin,
	input logic [uartRxPkg::addrBits-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [uartRxPkg::regBits-1:0] wdata,
	input logic [uartRxPkg::regBits/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [uartRxPkg::addrBits-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [uartRxPkg::regBits-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);
	logic lineOut;                                 // Pin or BIST serial data
	logic [uartRxPkg::divBits-1:0] baudDiv;
	logic [uartRxPkg::dataBits-1:0] rxByte;
	logic byteValid, frameErr;
	logic bistMode, bistStart, bistDone, bistPass;

	fifoIf fifoBus ();

	uartRxSampler uartRxSampler_i (.Clk(Clk), .rst(rst), .rxLine(lineOut),
		.baudDiv(baudDiv), .rxByte(rxByte), .byteValid(byteValid), .frameErr(frameErr));

	rxFifo rxFifo_i (.Clk(Clk), .rst(rst), .wrData(rxByte), .wrEn(byteValid),
		.bistMode(bistMode), .f(fifoBus.fifo));

	uartBist uartBist_i (.Clk(Clk), .rst(rst), .bistStart(bistStart), .baudDiv(baudDiv),
		.rxPin(rxPin), .rxByte(rxByte), .byteValid(byteValid), .frameErr(frameErr),
		.lineOut(lineOut), .bistMode(bistMode), .bistDone(bistDone), .bistPass(bistPass));

	axiLiteRegs axiLiteRegs_i (.Clk(Clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.frameErr(frameErr), .bistDone(bistDone), .bistPass(bistPass),
		.baudDiv(baudDiv), .bistStart(bistStart), .f(fifoBus.host));
endmodule

`default_nettype wire

// File: testbench/uartRx_props.sv
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the receive FIFO, bound into every rxFifo
// Checks are off while rst is high
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rxFifoProps (
	input logic Clk,
	input logic rst,
	input logic empty,
	input logic halfFull,
	input logic overflow,
	input logic pop,
	input logic wrEn,
	input logic bistMode,
	input logic [uartRxPkg::fifoAddrBits:0] count,
	input logic [uartRxPkg::fifoAddrBits-1:0] rdPtr,
	input logic [uartRxPkg::fifoAddrBits-1:0] wrPtr
);
	ovfHalf: assert property (@(posedge Clk) disable iff (rst) overflow |-> halfFull)
		else $error("overflow set while halfFull is low");

	emptyHalf: assert property (@(posedge Clk) disable iff (rst) !(empty && halfFull))
		else $error("empty and halfFull both high");

	frozenCount: assert property (@(posedge Clk) disable iff (rst) bistMode |=> $stable(count))
		else $error("FIFO count moved during BIST");

	// Write pointer is checked only when no push competes
	emptyPop: assert property (@(posedge Clk) disable iff (rst)
		pop && empty |=> $stable(rdPtr) && ($past(wrEn) || $stable(wrPtr)))
		else $error("pop on empty FIFO moved a pointer");
endmodule

bind rxFifo rxFifoProps rxFifoProps_i (.Clk(Clk), .rst(rst), .empty(f.empty),
	.halfFull(f.halfFull), .overflow(f.overflow), .pop(f.pop), .wrEn(wrEn),
	.bistMode(bistMode), .count(count), .rdPtr(rdPtr), .wrPtr(wrPtr));

`default_nettype wire

// File: testbench/tb_uartRx.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the UART receive subsystem
// Serial frames carry one idle bit after the stop bit
// Inputs change 1 ns after the rising edge, outputs are sampled
// on the falling edge
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_uartRx;
	localparam int totalFrames = 32;                 // All frames sent below
	localparam int watchdogNs = totalFrames * 11 * 16 * 4 + 20000;

	logic clk, rst, rxPin;
	logic [3:0] awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [31:0] wdata, rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp;
	logic [7:0] expQ[$];                             // Bytes expected from the FIFO
	int bitCycles;
	logic [31:0] word;
	logic [7:0] dropped;

	uartRxTop uartRxTop_i (.Clk(clk), .rst(rst), .rxPin(rxPin),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready));

	always #2 clk = ~clk;

	initial
	begin
		#(watchdogNs);
		$display("Timeout: the test sequence did not finish in %0d ns", watchdogNs);
		$display("Result: FAILED");
		$fatal(1, "Watchdog expired");
	end

	task automatic expectEqual(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "Value check failed");
		end
	endtask

	// Status word built from the register map bit positions
	function automatic logic [31:0] status(input logic empty, input logic half,
		input logic ovf, input logic ferr, input logic done, input logic pass);
		logic [31:0] w;
		w = '0;
		w[uartRxPkg::stEmpty] = empty;
		w[uartRxPkg::stHalf] = half;
		w[uartRxPkg::stOverflow] = ovf;
		w[uartRxPkg::stFrameErr] = ferr;
		w[uartRxPkg::stBistDone] = done;
		w[uartRxPkg::stBistPass] = pass;
		return w;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// AXI4-Lite master
	task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hF;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		while (!awready)
			@(negedge clk);
		expectEqual("wready", wready, 1);           // Pulses with awready
		@(posedge clk);                             // Accept edge
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		@(negedge clk);
		while (!bvalid)
			@(negedge clk);
		expectEqual("bresp", bresp, 0);
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axiRead(input logic [3:0] addr, output logic [31:0] data);
		@(posedge clk);
		#1;
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		rready = 1'b1;
		@(negedge clk);
		while (!rvalid)
			@(negedge clk);
		data = rdata;
		expectEqual("rresp", rresp, 0);
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic readExpect(input string name, input logic [3:0] addr,
		input logic [31:0] exp);
		logic [31:0] got;
		axiRead(addr, got);
		expectEqual(name, got, exp);
	endtask

	task automatic popExpect();
		logic [7:0] exp;
		exp = expQ.pop_front();
		readExpect("rdata", uartRxPkg::addrData, {24'b0, exp});
	endtask

	//////////////////////////////////////////////////////////////////////
	// Serial line model
	task automatic sendFrame(input logic [7:0] b, input logic stopLevel);
		logic [10:0] bits;
		bits = {1'b1, stopLevel, b, 1'b0};           // Idle, stop, data, start
		@(posedge clk);
		#1;
		for (int i = 0; i < 11; i++)
		begin
			rxPin = bits[i];
			repeat (bitCycles) @(posedge clk);
			#1;
		end
	endtask

	task automatic sendBytes(input int n);
		logic [7:0] b;
		for (int i = 0; i < n; i++)
		begin
			b = 8'($urandom());
			expQ.push_back(b);
			sendFrame(b, 1'b1);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		rxPin = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		bitCycles = uartRxPkg::defaultBaudDiv;
		word = $urandom(2);
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		// Idle bus after reset
		repeat (3)
		begin
			@(negedge clk);
			expectEqual("bvalid", bvalid, 0);
			expectEqual("rvalid", rvalid, 0);
			expectEqual("awready", awready, 0);
			expectEqual("wready", wready, 0);
			expectEqual("arready", arready, 0);
		end
		readExpect("status", uartRxPkg::addrStatus, status(1, 0, 0, 0, 0, 0));

		// Plain receive
		sendBytes(5);
		repeat (5) popExpect();
		readExpect("status", uartRxPkg::addrStatus, status(1, 0, 0, 0, 0, 0));
		readExpect("rdata", uartRxPkg::addrData, 32'd0);      // Empty FIFO reads 0
		readExpect("status", uartRxPkg::addrStatus, status(1, 0, 0, 0, 0, 0));

		// Half-full, overflow and a dropped byte
		sendBytes(8);
		readExpect("status", uartRxPkg::addrStatus, status(0, 1, 0, 0, 0, 0));
		sendBytes(8);
		readExpect("status", uartRxPkg::addrStatus, status(0, 1, 1, 0, 0, 0));
		dropped = 8'($urandom());
		sendFrame(dropped, 1'b1);                   // 17th byte, not queued
		readExpect("status", uartRxPkg::addrStatus, status(0, 1, 1, 0, 0, 0));
		popExpect();
		readExpect("status", uartRxPkg::addrStatus, status(0, 1, 0, 0, 0, 0));
		repeat (15) popExpect();
		readExpect("status", uartRxPkg::addrStatus, status(1, 0, 0, 0, 0, 0));

		// Low stop bit
		sendFrame(8'hA5, 1'b0);
		readExpect("status", uartRxPkg::addrStatus, status(1, 0, 0, 1, 0, 0));
		readExpect("status", uartRxPkg::addrStatus, status(1, 0, 0, 0, 0, 0));

		// Self-test with bytes already stored
		sendBytes(2);
		axiWrite(uartRxPkg::addrCtrl, (32'd1 << uartRxPkg::ctrlBistBit) | 32'd16);
		axiRead(uartRxPkg::addrStatus, word);
		while (!word[uartRxPkg::stBistDone])
			axiRead(uartRxPkg::addrStatus, word);
		expectEqual("bistPass", word[uartRxPkg::stBistPass], 1);
		readExpect("status", uartRxPkg::addrStatus, status(0, 0, 0, 0, 1, 1));
		repeat (2) popExpect();
		readExpect("status", uartRxPkg::addrStatus, status(1, 0, 0, 0, 1, 1));

		// New divisor and clamping
		axiWrite(uartRxPkg::addrCtrl, 32'd8);
		bitCycles = 8;
		readExpect("baudDiv", uartRxPkg::addrCtrl, 32'd8);
		sendBytes(3);
		repeat (3) popExpect();
		axiWrite(uartRxPkg::addrCtrl, 32'd2);
		readExpect("baudDiv", uartRxPkg::addrCtrl, {16'b0, uartRxPkg::minBaudDiv});

		$display("Result: PASSED");
		$finish;
	end
endmodule

`default_nettype wire

// File: src.f
hw/uartRxPkg.sv
hw/fifoIf.sv
hw/uartRxSampler.sv
hw/rxFifo.sv
hw/uartBist.sv
hw/axiLiteRegs.sv
hw/uartRxTop.sv
testbench/uartRx_props.sv
testbench/tb_uartRx.sv

// File: run.sh
#!/bin/sh
# Compile the UART receive testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module tb_uartRx --Mdir build -o sim_uartRx
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./build/sim_uartRx
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
exit 0
